// File: common/tune_pkg.sv
`default_nettype none

package tune_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////
    localparam int NOTE_PERIOD_W = 15;  // Tone period counter, in clocks.
    localparam int NOTE_DUR_W    = 24;  // Note length counter, in duration units.

    ////////////////////////////////////////////////////////////
    // Sequencer states
    ////////////////////////////////////////////////////////////
    // One state per note of the melody, in playing order.
    typedef enum logic [3:0] {
        IDLE,                           // Silent, waiting for go.
        D7,                             // First note.
        E7,
        F7,
        E7_2,                           // E7 again, dotted.
        F7_2,                           // F7 again, quarter.
        D7_2,                           // D7 again, dotted.
        A6,                             // Only note below octave 7.
        D7_3                            // Closing note.
    } note_state_t;

    ////////////////////////////////////////////////////////////
    // Pitches
    ////////////////////////////////////////////////////////////
    // Period in clocks at 50 MHz, one tone cycle is period + 1 clocks.
    localparam logic [NOTE_PERIOD_W-1:0] PERIOD_D7 = 15'd21286;  // About 2349 Hz.
    localparam logic [NOTE_PERIOD_W-1:0] PERIOD_E7 = 15'd18961;  // About 2637 Hz.
    localparam logic [NOTE_PERIOD_W-1:0] PERIOD_F7 = 15'd17895;  // About 2794 Hz.
    localparam logic [NOTE_PERIOD_W-1:0] PERIOD_A6 = 15'd28409;  // About 1760 Hz.

    ////////////////////////////////////////////////////////////
    // Durations
    ////////////////////////////////////////////////////////////
    // Counted in duration units, 2^20 units per sixteenth of a beat group.
    localparam logic [NOTE_DUR_W-1:0] DUR_QUARTER = 24'd4 << 20;   // 4 * 2^20.
    localparam logic [NOTE_DUR_W-1:0] DUR_HALF    = 24'd8 << 20;   // 8 * 2^20.
    localparam logic [NOTE_DUR_W-1:0] DUR_DOTTED  = 24'd12 << 20;  // 12 * 2^20.

endpackage

`default_nettype wire

// File: tune/tune_sequencer.sv
`default_nettype none

module tune_sequencer (
    input  logic                               clk,          // System clock.
    input  logic                               rst_n,        // Async reset, active low.
    input  logic                               go,           // Start strobe, one cycle.
    input  logic                               dur_done,     // Current note has run out.
    output logic [tune_pkg::NOTE_PERIOD_W-1:0] note_period,  // Pitch of current note.
    output logic [tune_pkg::NOTE_DUR_W-1:0]    note_dur,     // Length of current note.
    output logic                               clr_cnt,      // Restart both counters.
    output logic                               busy          // Melody is playing.
);
    import tune_pkg::*;

    note_state_t state;       // Current note.
    note_state_t nxt_state;   // Note after the next edge.

    ////////////////////////////////////////////////////////////
    // State register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            state <= IDLE;                  // Silent after reset.
        else
            state <= nxt_state;
    end

    ////////////////////////////////////////////////////////////
    // Next note and counter restart
    ////////////////////////////////////////////////////////////
    always_comb begin
        nxt_state = state;                  // Hold by default.
        clr_cnt   = 1'b0;
        case (state)
            IDLE: begin
                if (go) begin
                    nxt_state = D7;         // Go only counts here.
                    clr_cnt   = 1'b1;
                end
            end
            D7: if (dur_done) begin
                nxt_state = E7;
                clr_cnt   = 1'b1;
            end
            E7: if (dur_done) begin
                nxt_state = F7;
                clr_cnt   = 1'b1;
            end
            F7: if (dur_done) begin
                nxt_state = E7_2;
                clr_cnt   = 1'b1;
            end
            E7_2: if (dur_done) begin
                nxt_state = F7_2;
                clr_cnt   = 1'b1;
            end
            F7_2: if (dur_done) begin
                nxt_state = D7_2;
                clr_cnt   = 1'b1;
            end
            D7_2: if (dur_done) begin
                nxt_state = A6;
                clr_cnt   = 1'b1;
            end
            A6: if (dur_done) begin
                nxt_state = D7_3;
                clr_cnt   = 1'b1;
            end
            // Last note ends the tune, counters are left running.
            D7_3: if (dur_done) nxt_state = IDLE;
            default: nxt_state = IDLE;      // Recover from a bad encoding.
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Pitch and length decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (state)
            D7:      begin note_period = PERIOD_D7; note_dur = DUR_HALF;    end
            E7:      begin note_period = PERIOD_E7; note_dur = DUR_HALF;    end
            F7:      begin note_period = PERIOD_F7; note_dur = DUR_HALF;    end
            E7_2:    begin note_period = PERIOD_E7; note_dur = DUR_DOTTED;  end
            F7_2:    begin note_period = PERIOD_F7; note_dur = DUR_QUARTER; end
            D7_2:    begin note_period = PERIOD_D7; note_dur = DUR_DOTTED;  end
            A6:      begin note_period = PERIOD_A6; note_dur = DUR_QUARTER; end
            D7_3:    begin note_period = PERIOD_D7; note_dur = DUR_HALF;    end
            default: begin
                note_period = '0;           // Zero period keeps piezo low.
                note_dur    = '0;
            end
        endcase
    end

    assign busy = (state != IDLE);          // High for all eight notes.

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////
    a_state_legal : assert property (@(posedge clk) disable iff (!rst_n)
        state inside {IDLE, D7, E7, F7, E7_2, F7_2, D7_2, A6, D7_3})
        else $error("Sequencer state left the enum.");

    // A restart must give the new note at least one clock of count.
    a_clr_single : assert property (@(posedge clk) disable iff (!rst_n)
        clr_cnt |=> !clr_cnt)
        else $error("clr_cnt high on two cycles in a row.");

endmodule

`default_nettype wire

// File: tune/note_timer.sv
`default_nettype none

module note_timer #(
    parameter int unsigned DUR_INC = 1                      // Units added per clock.
) (
    input  logic                            clk,            // System clock.
    input  logic                            rst_n,          // Async reset, active low.
    input  logic                            clr_cnt,        // Start of a new note.
    input  logic [tune_pkg::NOTE_DUR_W-1:0] note_dur,       // Length of current note.
    output logic                            dur_done        // Count has reached note_dur.
);
    import tune_pkg::*;

    localparam logic [NOTE_DUR_W-1:0] DUR_STEP = NOTE_DUR_W'(DUR_INC);  // Sized step.

    logic [NOTE_DUR_W-1:0] dur_cnt;  // Units elapsed in the current note.

    ////////////////////////////////////////////////////////////
    // Duration counter
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            dur_cnt <= '0;
        else if (clr_cnt)
            dur_cnt <= '0;                      // New note starts from zero.
        else
            dur_cnt <= dur_cnt + DUR_STEP;      // Free runs, wraps in IDLE.
    end

    // Level, so the sequencer sees it on the last clock of the note.
    assign dur_done = (dur_cnt == note_dur);

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////
    // Overshoot means DUR_INC does not divide the note length.
    a_no_overshoot : assert property (@(posedge clk) disable iff (!rst_n)
        (note_dur != '0) |-> (dur_cnt <= note_dur))
        else $error("Duration count passed note_dur, DUR_INC = %0d.", DUR_INC);

endmodule

`default_nettype wire

// File: tune/tone_gen.sv
`default_nettype none

module tone_gen (
    input  logic                               clk,          // System clock.
    input  logic                               rst_n,        // Async reset, active low.
    input  logic                               clr_cnt,      // Start of a new note.
    input  logic [tune_pkg::NOTE_PERIOD_W-1:0] note_period,  // Tone period in clocks.
    output logic                               piezo,        // Buzzer drive.
    output logic                               piezo_n       // Opposite buzzer terminal.
);
    import tune_pkg::*;

    logic [NOTE_PERIOD_W-1:0] period_cnt;   // Clock within the tone cycle.
    logic [NOTE_PERIOD_W-1:0] half_period;  // Clocks of high time per cycle.
    logic                     cycle_end;    // Last clock of a tone cycle.

    ////////////////////////////////////////////////////////////
    // Period counter
    ////////////////////////////////////////////////////////////
    // Greater-or-equal also pulls the count back after the last note.
    assign cycle_end = (period_cnt >= note_period);

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            period_cnt <= '0;
        else if (clr_cnt)
            period_cnt <= '0;                   // Phase aligned to note start.
        else if (cycle_end)
            period_cnt <= '0;                   // Wrap, period + 1 clocks per cycle.
        else
            period_cnt <= period_cnt + 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // Square wave
    ////////////////////////////////////////////////////////////
    assign half_period = {1'b0, note_period[NOTE_PERIOD_W-1:1]};  // Rounded down.

    // High for the first half, so every note starts high.
    assign piezo   = (period_cnt < half_period);
    assign piezo_n = ~piezo;                    // Drives the piezo differentially.

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////
    // Note changes clear the count, so it stays inside the new period.
    a_cnt_in_period : assert property (@(posedge clk) disable iff (!rst_n)
        (note_period != '0) |-> (period_cnt <= note_period))
        else $error("Period count above note_period.");

endmodule

`default_nettype wire

// File: hdl/tune_player.sv
`default_nettype none

module tune_player #(
    parameter int unsigned DUR_INC = 1      // Duration units per clock, larger in simulation.
) (
    input  logic clk,                       // System clock, 50 MHz.
    input  logic rst_n,                     // Async reset, active low.
    input  logic go,                        // Start strobe, ignored while busy.
    output logic busy,                      // Melody in progress.
    output logic piezo,                     // Buzzer drive.
    output logic piezo_n                    // Complement of piezo.
);
    import tune_pkg::*;

    ////////////////////////////////////////////////////////////
    // Internal nets
    ////////////////////////////////////////////////////////////
    logic [NOTE_PERIOD_W-1:0] note_period;  // Sequencer to tone generator.
    logic [NOTE_DUR_W-1:0]    note_dur;     // Sequencer to timer.
    logic                     clr_cnt;      // Restart of both counters.
    logic                     dur_done;     // Timer back to sequencer.

    ////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////
    tune_sequencer i_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .go          (go),
        .dur_done    (dur_done),
        .note_period (note_period),
        .note_dur    (note_dur),
        .clr_cnt     (clr_cnt),
        .busy        (busy)
    );

    note_timer #(
        .DUR_INC (DUR_INC)
    ) i_timer (
        .clk      (clk),
        .rst_n    (rst_n),
        .clr_cnt  (clr_cnt),
        .note_dur (note_dur),
        .dur_done (dur_done)
    );

    // Pitch only, the timer decides when a note ends.
    tone_gen i_tone (
        .clk         (clk),
        .rst_n       (rst_n),
        .clr_cnt     (clr_cnt),
        .note_period (note_period),
        .piezo       (piezo),
        .piezo_n     (piezo_n)
    );

endmodule

`default_nettype wire

// File: dv/tune_player_tb.sv
`default_nettype none

module tune_player_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import tune_pkg::*;

    localparam int unsigned DUR_INC    = 64;  // Fast playback for simulation.
    localparam int          BUSY_WAIT  = 8;   // Clocks allowed from go to busy.
    localparam int          MELODY_LEN = 8;   // Notes per melody.

    logic clk;
    logic rst_n;
    logic go;
    logic busy;
    logic piezo;
    logic piezo_n;

    int seed = 82;     // Fixed seed for the idle gaps and extra go pulses.
    int checks;        // Comparisons made.
    int errors;        // Comparisons and waits that went wrong.
    bit aborted;       // Set by a timeout, skips the remaining tests.

    tune_player #(
        .DUR_INC (DUR_INC)
    ) i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .go      (go),
        .busy    (busy),
        .piezo   (piezo),
        .piezo_n (piezo_n)
    );

    ////////////////////////////////////////////////////////////
    // Clock and helpers
    ////////////////////////////////////////////////////////////
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period.
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Mismatch %s: expected 0x%0h, actual 0x%0h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    // Melody order D7 E7 F7 E7 F7 D7 A6 D7, length in clocks per note.
    function automatic void expected_note(input int idx, output int period, output int len);
        logic [NOTE_DUR_W-1:0] dur;
        case (idx)
            0:       begin period = PERIOD_D7; dur = DUR_HALF;    end
            1:       begin period = PERIOD_E7; dur = DUR_HALF;    end
            2:       begin period = PERIOD_F7; dur = DUR_HALF;    end
            3:       begin period = PERIOD_E7; dur = DUR_DOTTED;  end
            4:       begin period = PERIOD_F7; dur = DUR_QUARTER; end
            5:       begin period = PERIOD_D7; dur = DUR_DOTTED;  end
            6:       begin period = PERIOD_A6; dur = DUR_QUARTER; end
            7:       begin period = PERIOD_D7; dur = DUR_HALF;    end
            default: begin period = 0;         dur = '0;          end
        endcase
        len = dur / DUR_INC + 1;  // Last count value takes one more clock.
    endfunction

    task automatic idle_gap(input int cycles);
        repeat (cycles) begin
            @(negedge clk);  // Outputs settled half a clock after the edge.
            check_value("busy", 0, busy);
            check_value("piezo", 0, piezo);
            check_value("piezo_n", 1, piezo_n);
        end
    endtask

    task automatic pulse_go();
        @(posedge clk);
        #1 go = 1'b1;
        @(posedge clk);  // DUT samples go here.
        #1 go = 1'b0;
    endtask

    // Extra go pulses at random points of a running melody.
    task automatic pulse_while_busy(input int count);
        int gap;
        repeat (count) begin
            gap = 1000 + ($unsigned($random(seed)) % 60000);
            repeat (gap) @(posedge clk);
            #1;
            if (!busy) begin
                errors++;
                $display("Extra go pulse came after playback had already ended");
            end
            go = 1'b1;
            @(posedge clk);
            #1 go = 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Melody monitor
    ////////////////////////////////////////////////////////////
    task automatic check_melody(input string tag);
        int waited;
        int rel;
        int note_start;
        int busy_cnt;
        int period;
        int len;
        int high_run;
        int low_run;
        int phase;
        int n;
        @(negedge clk);
        waited = 0;
        while (!busy && waited < BUSY_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!busy) begin
            errors++;
            aborted = 1'b1;
            $display("Timeout: busy did not rise within %0d clocks of go (%s)", BUSY_WAIT, tag);
            return;
        end
        check_value("busy_delay", 0, waited);  // Busy from the edge that took go.
        rel        = 0;
        note_start = 0;
        busy_cnt   = 0;
        for (n = 0; n < MELODY_LEN; n++) begin
            expected_note(n, period, len);
            high_run = 0;
            low_run  = 0;
            phase    = 0;  // 0 high run, 1 low run, 2 first cycle done.
            check_value($sformatf("piezo_note_start[%0d]", n), 1, piezo);
            while (rel < note_start + len) begin
                if (busy)
                    busy_cnt++;
                if (phase == 0) begin
                    if (piezo) begin
                        high_run++;
                    end else begin
                        phase   = 1;
                        low_run = 1;
                    end
                end else if (phase == 1) begin
                    if (!piezo)
                        low_run++;
                    else
                        phase = 2;
                end
                @(negedge clk);
                rel++;
            end
            note_start += len;  // Running start cycle of the next note.
            check_value($sformatf("piezo_high_run[%0d]", n), period / 2, high_run);
            check_value($sformatf("tone_cycle_len[%0d]", n), period + 1, high_run + low_run);
        end
        check_value("busy_length", note_start, busy_cnt);
        check_value("busy_after_melody", 0, busy);
        check_value("piezo_after_melody", 0, piezo);
    endtask

    // Complementary drive, checked on every cycle out of reset.
    always @(negedge clk) begin
        if (rst_n)
            check_value("piezo_n", !piezo, piezo_n);
    end

    task automatic report_test(input int num, input string name, input int errs_before);
        $display("test %0d (%s) finished with %0d errors", num, name, errors - errs_before);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    initial begin
        int errs_before;
        rst_n   = 1'b0;
        go      = 1'b0;
        checks  = 0;
        errors  = 0;
        aborted = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;

        errs_before = errors;
        idle_gap(20 + ($unsigned($random(seed)) % 50));
        report_test(1, "idle after reset", errs_before);

        if (!aborted) begin
            errs_before = errors;
            idle_gap(5 + ($unsigned($random(seed)) % 30));
            pulse_go();
            check_melody("single go");
            report_test(2, "single melody", errs_before);
        end

        if (!aborted) begin
            errs_before = errors;
            idle_gap(5 + ($unsigned($random(seed)) % 30));
            pulse_go();
            fork
                check_melody("go while busy");
                pulse_while_busy(4);
            join
            report_test(3, "go ignored while busy", errs_before);
        end

        if (!aborted) begin
            errs_before = errors;
            idle_gap(5 + ($unsigned($random(seed)) % 30));
            pulse_go();
            check_melody("replay");
            idle_gap(10);  // Silent again after the replay.
            report_test(4, "replay after melody", errs_before);
        end

        $display("Checks: %0d run, %0d errors", checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tune_player.f
common/tune_pkg.sv
tune/tune_sequencer.sv
tune/note_timer.sv
tune/tone_gen.sv
hdl/tune_player.sv
dv/tune_player_tb.sv
